// ==== source/gpu_params.svh ====
`ifndef GPU_PARAMS_SVH
`define GPU_PARAMS_SVH

// GP0 environment opcodes, found in bits 31:24 of the command word
`define GP0_NOP          8'h03   // No operation
`define GP0_IRQ_REQ      8'h1F   // Raise GPU interrupt
`define GP0_DRAW_MODE    8'hE1   // Texpage, dither, semi-trans
`define GP0_TEX_WINDOW   8'hE2   // Texture window mask/offset
`define GP0_AREA_TL      8'hE3   // Drawing area top-left
`define GP0_AREA_BR      8'hE4   // Drawing area bottom-right
`define GP0_DRAW_OFFSET  8'hE5   // Drawing offset
`define GP0_MASK         8'hE6   // Mask bit handling

// GP1 opcodes, executed immediately
`define GP1_RESET        8'h00   // Full GPU reset
`define GP1_RESET_FIFO   8'h01   // Flush command buffer
`define GP1_ACK_IRQ      8'h02   // Clear irq flag
`define GP1_DISPLAY_EN   8'h03   // Bit 0 set turns display off
`define GP1_DMA_DIR      8'h04   // DMA direction in bits 1:0
`define GP1_DISPLAY_MODE 8'h08   // Resolution, video mode, depth
`define GP1_GET_INFO     8'h10   // Latch info into GPUREAD

`define GPU_STAT_RESET   32'h1480_2000 // Display off, idle, ready
`define GPU_VERSION      32'd2         // Info index 7

`define CMD_FIFO_DEPTH   16
`define CMD_FIFO_AW      4

// Wishbone word addresses
`define ADR_GP0          1'b0    // GP0 write, GPUREAD read
`define ADR_GP1          1'b1    // GP1 write, GPUSTAT read

`endif

// ==== source/gpu_pkg.sv ====
package gpu_pkg;

   // Wishbone classic request from the CPU side
   typedef struct packed {
      logic        cyc;       // Bus cycle in progress
      logic        stb;       // Strobe for this transfer
      logic        we;        // Write enable
      logic        adr;       // Word address, GP0/GP1
      logic [31:0] dat;       // Write data
   } wb_req_t;

   // GPUSTAT, MSB first
   typedef struct packed {
      logic       rsvd31;
      logic [1:0] dma_dir;    // 30:29
      logic       cmd_idle;   // FIFO empty
      logic       rsvd27;
      logic       cmd_ready;  // FIFO not full
      logic       rsvd25;
      logic       irq;        // 24
      logic       display_off;
      logic       interlace;
      logic       color_depth;
      logic       video_mode;
      logic       vres;       // 19
      logic [1:0] hres1;      // 18:17
      logic       hres2;      // 16
      logic       tex_disable;
      logic       reverse;
      logic       interlace_field; // Held at 1
      logic       mask_en;    // 12
      logic       set_mask;   // 11
      logic       draw_to_display;
      logic       dither;
      logic [1:0] tex_depth;  // 8:7
      logic [1:0] semi_trans; // 6:5
      logic       tex_page_y;
      logic [3:0] tex_page_x; // 3:0
   } gpu_stat_t;

   // GP0 word views, one per opcode family
   typedef struct packed {
      logic [7:0]  opcode;
      logic [23:0] param;     // Generic parameter field
   } gp0_raw_t;

   typedef struct packed {
      logic [7:0]  opcode;
      logic [11:0] rsvd;
      logic        tex_disable;
      logic [10:0] mode;      // Maps onto GPUSTAT 10:0
   } gp0_mode_t;

   typedef struct packed {
      logic [7:0] opcode;
      logic [3:0] rsvd;
      logic [9:0] y;
      logic [9:0] x;
   } gp0_area_t;

   typedef struct packed {
      logic [7:0]  opcode;
      logic [1:0]  rsvd;
      logic [10:0] y;         // Signed offsets
      logic [10:0] x;
   } gp0_ofs_t;

   typedef struct packed {
      logic [7:0]  opcode;
      logic [21:0] rsvd;
      logic        mask_en;   // Check mask before draw
      logic        set_mask;  // Force mask bit on write
   } gp0_mask_t;

   typedef union packed {
      gp0_raw_t  raw;
      gp0_mode_t mode;
      gp0_area_t area;
      gp0_ofs_t  ofs;
      gp0_mask_t mask;
   } gp0_word_u;

   // Drawing environment set by GP0 E2..E5
   typedef struct packed {
      logic [19:0] tex_window;
      logic [19:0] area_tl;   // {y, x}
      logic [19:0] area_br;   // {y, x}
      logic [21:0] offset;    // {y, x}
   } draw_env_t;

   // GPUSTAT bits owned by the GP0 decoder
   typedef struct packed {
      logic        tex_disable; // Bit 15
      logic        mask_en;     // Bit 12
      logic        set_mask;    // Bit 11
      logic [10:0] mode;        // Bits 10:0
   } draw_mode_t;

endpackage

// ==== source/cmd_fifo.sv ====
module cmd_fifo #(
   parameter int DEPTH = 16
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,     // Flush, beats push
   input  logic        push,
   input  logic [31:0] din,
   input  logic        pop,
   output logic [31:0] head,    // Oldest word
   output logic        full,
   output logic        empty
);
   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

   logic [31:0]   mem [DEPTH];    // Word storage
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;          // Occupancy
   logic          do_push;
   logic          do_pop;

   // Wrap at DEPTH, not only at a power of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      if (ptr == AW'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full    = (count == FULL_CNT);
   assign empty   = (count == '0);
   assign do_push = push & ~full;    // Drop on overflow
   assign do_pop  = pop & ~empty;
   assign head    = mem[rd_ptr];     // Show-ahead read

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clr) begin
         wr_ptr <= '0;                // Empty in one cycle
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

endmodule

// ==== source/host_port.sv ====
`include "gpu_params.svh"

module host_port import gpu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  wb_req_t     wb_req,
   output logic        wb_ack,
   output logic [31:0] wb_rdata,
   input  logic        fifo_full,
   input  gpu_stat_t   gpustat,
   input  logic [31:0] gpuread,
   output logic        gp0_push,
   output logic [31:0] gp0_word,
   output logic        gp1_valid,
   output logic [31:0] gp1_word
);
   logic req_seen;    // New request, not yet acked
   logic wr_gp0;
   logic wr_gp1;
   logic gp0_stall;   // Wait state while FIFO full
   logic ack_next;

   assign req_seen  = wb_req.cyc & wb_req.stb & ~wb_ack;
   assign wr_gp0    = wb_req.we & (wb_req.adr == `ADR_GP0);
   assign wr_gp1    = wb_req.we & (wb_req.adr == `ADR_GP1);
   assign gp0_stall = wr_gp0 & fifo_full;
   assign ack_next  = req_seen & ~gp0_stall;

   // Single-cycle ack, one cycle after the request shows up
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= ack_next;
      end
   end

   // Writes land on the same edge that registers ack
   assign gp0_push  = ack_next & wr_gp0 & (wb_req.dat != '0); // Zero never buffered
   assign gp0_word  = wb_req.dat;
   assign gp1_valid = ack_next & wr_gp1;
   assign gp1_word  = wb_req.dat;

   // Read data follows the registers during the ack cycle
   always_comb begin
      case (wb_req.adr)
         `ADR_GP1: wb_rdata = gpustat;
         default:  wb_rdata = gpuread;  // GPUREAD at address 0
      endcase
   end

endmodule

// ==== source/gp1_control.sv ====
`include "gpu_params.svh"

module gp1_control import gpu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        gp1_valid,
   input  logic [31:0] gp1_word,
   input  logic        irq_req,     // From GP0 0x1F
   input  draw_env_t   env,
   output logic        fifo_clr,
   output logic        env_clr,
   output gpu_stat_t   disp_stat,
   output logic [31:0] gpuread
);
   logic [7:0]  opcode;
   logic [3:0]  info_idx;   // GET_INFO selector
   gpu_stat_t   stat_q;
   logic        rd_ld;
   logic [31:0] rd_new;

   assign opcode   = gp1_word[31:24];
   assign info_idx = gp1_word[3:0];

   // Clear pulses act on the same edge as the GP1 write
   assign env_clr  = gp1_valid & (opcode == `GP1_RESET);
   assign fifo_clr = gp1_valid & ((opcode == `GP1_RESET) | (opcode == `GP1_RESET_FIFO));

   // GET_INFO source select
   always_comb begin
      rd_ld  = gp1_valid & (opcode == `GP1_GET_INFO);
      rd_new = gpuread;
      case (info_idx)
         4'h2:    rd_new = {12'd0, env.tex_window};
         4'h3:    rd_new = {12'd0, env.area_tl};
         4'h4:    rd_new = {12'd0, env.area_br};
         4'h5:    rd_new = {10'd0, env.offset};
         4'h7:    rd_new = `GPU_VERSION;
         4'h8:    rd_new = '0;
         default: rd_ld  = 1'b0;          // Unlisted index keeps GPUREAD
      endcase
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         stat_q  <= gpu_stat_t'(`GPU_STAT_RESET);
         gpuread <= '0;
      end else begin
         if (gp1_valid) begin
            case (opcode)
               `GP1_RESET: begin
                  stat_q  <= gpu_stat_t'(`GPU_STAT_RESET);
                  gpuread <= '0;
               end
               `GP1_ACK_IRQ:    stat_q.irq         <= 1'b0;
               `GP1_DISPLAY_EN: stat_q.display_off <= gp1_word[0]; // 1 blanks output
               `GP1_DMA_DIR:    stat_q.dma_dir     <= gp1_word[1:0];
               `GP1_DISPLAY_MODE: begin
                  stat_q.hres1       <= gp1_word[1:0];
                  stat_q.vres        <= gp1_word[2];
                  stat_q.video_mode  <= gp1_word[3];  // NTSC/PAL
                  stat_q.color_depth <= gp1_word[4];
                  stat_q.interlace   <= gp1_word[5];
                  stat_q.hres2       <= gp1_word[6];
                  stat_q.reverse     <= gp1_word[7];
               end
               default: ;                         // FIFO flush and info handled elsewhere
            endcase
         end
         if (rd_ld) begin
            gpuread <= rd_new;
         end
         if (irq_req) begin
            stat_q.irq <= 1'b1;                   // Request beats ack
         end
      end
   end

   // Fields owned elsewhere are overridden at the top level
   assign disp_stat = stat_q;

endmodule

// ==== source/gp0_decoder.sv ====
`include "gpu_params.svh"

module gp0_decoder import gpu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        env_clr,   // GP1 reset
   input  logic [31:0] head,
   input  logic        empty,
   output logic        pop,
   output logic        irq_req,   // One-cycle pulse
   output draw_mode_t  draw_mode,
   output draw_env_t   env
);
   gp0_word_u cmd;

   assign cmd = head;       // Decode through opcode views
   assign pop = ~empty;     // Every command is a single word here

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         irq_req   <= 1'b0;
         draw_mode <= '0;
         env       <= '0;
      end else if (env_clr) begin
         irq_req   <= 1'b0;   // Popped word is dropped with the flush
         draw_mode <= '0;
         env       <= '0;
      end else begin
         irq_req <= 1'b0;
         if (pop) begin
            case (cmd.raw.opcode)
               `GP0_NOP: ;
               `GP0_IRQ_REQ: begin
                  irq_req <= 1'b1;
               end
               `GP0_DRAW_MODE: begin
                  draw_mode.mode        <= cmd.mode.mode;
                  draw_mode.tex_disable <= cmd.mode.tex_disable;
               end
               `GP0_TEX_WINDOW: begin
                  env.tex_window <= cmd.raw.param[19:0]; // Mask and offset
               end
               `GP0_AREA_TL: begin
                  env.area_tl <= {cmd.area.y, cmd.area.x};
               end
               `GP0_AREA_BR: begin
                  env.area_br <= {cmd.area.y, cmd.area.x};
               end
               `GP0_DRAW_OFFSET: begin
                  env.offset <= {cmd.ofs.y, cmd.ofs.x};
               end
               `GP0_MASK: begin
                  draw_mode.set_mask <= cmd.mask.set_mask;
                  draw_mode.mask_en  <= cmd.mask.mask_en;
               end
               default: ;   // Render opcodes, popped and discarded
            endcase
         end
      end
   end

endmodule

// ==== source/gpu_top.sv ====
`include "gpu_params.svh"

module gpu_top import gpu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  wb_req_t     wb_req,
   output logic        wb_ack,
   output logic [31:0] wb_rdata
);
   logic        gp0_push;
   logic [31:0] gp0_word;
   logic        gp1_valid;
   logic [31:0] gp1_word;
   logic        fifo_full;
   logic        fifo_empty;
   logic        fifo_clr;
   logic [31:0] fifo_head;
   logic        pop;
   logic        env_clr;
   logic        irq_req;
   draw_mode_t  draw_mode;
   draw_env_t   env;
   gpu_stat_t   disp_stat;
   gpu_stat_t   gpustat;
   logic [31:0] gpuread;

   host_port u_host_port (
      .clk, .rst, .wb_req, .wb_ack, .wb_rdata,
      .fifo_full, .gpustat, .gpuread,
      .gp0_push, .gp0_word, .gp1_valid, .gp1_word
   );

   cmd_fifo #(.DEPTH(`CMD_FIFO_DEPTH)) u_cmd_fifo (
      .clk, .rst, .clr(fifo_clr), .push(gp0_push), .din(gp0_word),
      .pop, .head(fifo_head), .full(fifo_full), .empty(fifo_empty)
   );

   gp0_decoder u_gp0_decoder (
      .clk, .rst, .env_clr, .head(fifo_head), .empty(fifo_empty),
      .pop, .irq_req, .draw_mode, .env
   );

   gp1_control u_gp1_control (
      .clk, .rst, .gp1_valid, .gp1_word, .irq_req, .env,
      .fifo_clr, .env_clr, .disp_stat, .gpuread
   );

   // GPUSTAT merge
   always_comb begin
      gpustat = disp_stat;                       // Display, DMA, irq
      {gpustat.draw_to_display, gpustat.dither, gpustat.tex_depth,
       gpustat.semi_trans, gpustat.tex_page_y, gpustat.tex_page_x} = draw_mode.mode;
      gpustat.tex_disable     = draw_mode.tex_disable;
      gpustat.mask_en         = draw_mode.mask_en;
      gpustat.set_mask        = draw_mode.set_mask;
      gpustat.interlace_field = 1'b1;            // No video timing
      gpustat.cmd_ready       = ~fifo_full;
      gpustat.cmd_idle        = fifo_empty;
      gpustat.rsvd25          = 1'b0;
      gpustat.rsvd27          = 1'b0;
      gpustat.rsvd31          = 1'b0;
   end

endmodule

// ==== tb/tb_gpu.sv ====
`include "gpu_params.svh"

module tb_gpu import gpu_pkg::*; ();
   localparam int ACK_LIMIT     = 20;              // Cycles before a missing ack is an error
   localparam int IDLE_POLLS    = 50;              // GPUSTAT reads while waiting for drain
   localparam int WATCHDOG_TIME = 5 * 400 * 20;    // Five tests of 400 cycles each

   logic        clk;
   logic        rst;
   wb_req_t     wb_req;
   logic        wb_ack;
   logic [31:0] wb_rdata;

   logic [31:0] lcg_state;
   logic [31:0] exp_stat;      // Expected GPUSTAT carried across tests
   int          errors;
   int          tests_passed;
   int          tests_failed;

   gpu_top dut0 (.clk, .rst, .wb_req, .wb_ack, .wb_rdata);

   always #10 clk = ~clk;      // 20 unit period

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, actual, expected);
         errors++;
      end
   endtask

   // One Wishbone classic transfer entered 1 unit after a rising edge
   task automatic wb_xfer(input logic we, input logic adr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
      int waits;
      waits      = 0;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdata;
      do begin
         @(posedge clk);
         #1;                                      // Sample away from the edge
         waits++;
      end while (!wb_ack && waits < ACK_LIMIT);
      rdata = wb_rdata;                           // Valid in the ack cycle
      if (!wb_ack) begin
         $display("Bus transfer to address %0d got no acknowledge within %0d cycles",
                  adr, ACK_LIMIT);
         errors++;
      end
      wb_req = '0;                                // Drop stb after ack
   endtask

   task automatic wb_write(input logic adr, input logic [31:0] data);
      logic [31:0] unused;
      wb_xfer(1'b1, adr, data, unused);
   endtask

   task automatic wb_read(input logic adr, output logic [31:0] data);
      wb_xfer(1'b0, adr, 32'd0, data);
   endtask

   // Poll GPUSTAT until the command FIFO reports idle
   task automatic wait_idle();
      logic [31:0] stat;
      int          polls;
      polls = 0;
      do begin
         wb_read(`ADR_GP1, stat);
         polls++;
      end while (!stat[28] && polls < IDLE_POLLS);
      if (!stat[28]) begin
         $display("GP0 commands did not drain, FIFO still busy after %0d status reads",
                  IDLE_POLLS);
         errors++;
      end
   endtask

   task automatic read_info(input logic [3:0] idx, output logic [31:0] value);
      wb_write(`ADR_GP1, {`GP1_GET_INFO, 20'd0, idx});
      wb_read(`ADR_GP0, value);                   // GPUREAD
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   task automatic test_reset_values();
      logic [31:0] rd;
      int          start;
      start    = errors;
      exp_stat = `GPU_STAT_RESET;
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      wb_read(`ADR_GP0, rd);
      check("GPUREAD", rd, 32'd0);
      report_test("test_reset_values", start);
   endtask

   task automatic test_gp1_display();
      logic [31:0] rd;
      logic [7:0]  mode;
      logic [1:0]  dma;
      int          start;
      start = errors;
      mode  = 8'(next_rand());
      dma   = 2'(next_rand());
      wb_write(`ADR_GP1, {`GP1_DISPLAY_EN, 24'd0});          // Display on
      wb_write(`ADR_GP1, {`GP1_DMA_DIR, 22'd0, dma});
      wb_write(`ADR_GP1, {`GP1_DISPLAY_MODE, 16'd0, mode});
      exp_stat[23]    = 1'b0;
      exp_stat[30:29] = dma;
      exp_stat[18:17] = mode[1:0];                           // hres1
      exp_stat[19]    = mode[2];                             // vres
      exp_stat[20]    = mode[3];                             // Video mode
      exp_stat[21]    = mode[4];                             // Color depth
      exp_stat[22]    = mode[5];                             // Interlace
      exp_stat[16]    = mode[6];                             // hres2
      exp_stat[14]    = mode[7];                             // Reverse
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      wb_write(`ADR_GP1, {`GP1_DISPLAY_EN, 23'd0, 1'b1});    // Display off again
      exp_stat[23] = 1'b1;
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      report_test("test_gp1_display", start);
   endtask

   task automatic test_gp0_draw_mode();
      logic [31:0] rd;
      logic [11:0] mode_bits;
      int          start;
      start     = errors;
      mode_bits = 12'(next_rand());
      wb_write(`ADR_GP0, {`GP0_DRAW_MODE, 12'd0, mode_bits});
      wb_write(`ADR_GP0, {`GP0_MASK, 22'd0, 2'b10});         // mask_en only
      wait_idle();
      exp_stat[10:0] = mode_bits[10:0];
      exp_stat[15]   = mode_bits[11];                        // Texture disable
      exp_stat[11]   = 1'b0;                                 // set_mask
      exp_stat[12]   = 1'b1;                                 // mask_en
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      wb_write(`ADR_GP0, 32'd0);                             // Acked but never buffered
      wait_idle();
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      read_info(4'h7, rd);                                   // Load GPUREAD before reset
      check("GPUREAD", rd, `GPU_VERSION);
      wb_write(`ADR_GP1, {`GP1_RESET, 24'd0});
      exp_stat = `GPU_STAT_RESET;
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      wb_read(`ADR_GP0, rd);
      check("GPUREAD", rd, 32'd0);
      report_test("test_gp0_draw_mode", start);
   endtask

   task automatic test_get_info();
      logic [31:0] rd;
      logic [19:0] tw;
      logic [19:0] tl;
      logic [19:0] br;
      logic [21:0] ofs;
      int          start;
      start = errors;
      tw    = 20'(next_rand());
      tl    = 20'(next_rand());
      br    = 20'(next_rand());
      ofs   = 22'(next_rand());
      wb_write(`ADR_GP0, {`GP0_TEX_WINDOW, 4'd0, tw});
      wb_write(`ADR_GP0, {`GP0_AREA_TL, 4'd0, tl});          // y above x
      wb_write(`ADR_GP0, {`GP0_AREA_BR, 4'd0, br});
      wb_write(`ADR_GP0, {`GP0_DRAW_OFFSET, 2'd0, ofs});
      wait_idle();
      read_info(4'h2, rd);
      check("GPUREAD tex_window", rd, {12'd0, tw});
      read_info(4'h3, rd);
      check("GPUREAD area_tl", rd, {12'd0, tl});
      read_info(4'h4, rd);
      check("GPUREAD area_br", rd, {12'd0, br});
      read_info(4'h5, rd);
      check("GPUREAD offset", rd, {10'd0, ofs});
      read_info(4'h7, rd);
      check("GPUREAD version", rd, `GPU_VERSION);
      read_info(4'h8, rd);
      check("GPUREAD zero", rd, 32'd0);
      read_info(4'h2, rd);
      read_info(4'h9, rd);                                   // Unlisted index keeps last value
      check("GPUREAD unchanged", rd, {12'd0, tw});
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      report_test("test_get_info", start);
   endtask

   task automatic test_irq_and_burst();
      logic [31:0] rd;
      logic [19:0] tl [3];
      logic [19:0] br;
      int          start;
      start = errors;
      wb_write(`ADR_GP0, {`GP0_IRQ_REQ, 24'd0});
      wait_idle();
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT irq", 32'(rd[24]), 32'd1);
      wb_write(`ADR_GP1, {`GP1_ACK_IRQ, 24'd0});
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      for (int i = 0; i < 3; i++) begin
         tl[i] = 20'(next_rand());
      end
      br = 20'(next_rand());
      wb_write(`ADR_GP0, {`GP0_AREA_TL, 4'd0, tl[0]});       // Back-to-back without polling
      wb_write(`ADR_GP0, {`GP0_NOP, 24'd0});
      wb_write(`ADR_GP0, {`GP0_AREA_TL, 4'd0, tl[1]});
      wb_write(`ADR_GP0, 32'h2800_0000);                     // Render opcode is discarded
      wb_write(`ADR_GP0, {`GP0_AREA_BR, 4'd0, br});
      wb_write(`ADR_GP0, {`GP0_AREA_TL, 4'd0, tl[2]});
      wait_idle();
      read_info(4'h3, rd);
      check("GPUREAD area_tl", rd, {12'd0, tl[2]});          // Last write wins
      read_info(4'h4, rd);
      check("GPUREAD area_br", rd, {12'd0, br});
      wb_read(`ADR_GP1, rd);
      check("GPUSTAT", rd, exp_stat);
      report_test("test_irq_and_burst", start);
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      wb_req       = '0;
      lcg_state    = 32'ha52;
      exp_stat     = `GPU_STAT_RESET;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;                               // Release off the edge
      test_reset_values();
      test_gp1_display();
      test_gp0_draw_mode();
      test_get_info();
      test_irq_and_burst();
      $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("Timeout: simulation still running after %0d time units", WATCHDOG_TIME);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+source
source/gpu_pkg.sv
source/cmd_fifo.sv
source/host_port.sv
source/gp1_control.sv
source/gp0_decoder.sv
source/gpu_top.sv
tb/tb_gpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gpu
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q 'All tests passed!' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
